// File: src/ex_pkg.sv
`default_nettype none

package ex_pkg;

    localparam int XLEN     = 64;
    localparam int PC_W     = 32;
    localparam int LA_GROUP = 8;

    // RV64I major opcodes handled by the execute stage
    typedef enum logic [6:0] {
        OP_64     = 7'b0110011,
        OP_32     = 7'b0111011,
        OP_IMM    = 7'b0010011,
        OP_IMM_32 = 7'b0011011,
        LOAD      = 7'b0000011,
        STORE     = 7'b0100011,
        BRANCH    = 7'b1100011,
        JAL       = 7'b1101111,
        JALR      = 7'b1100111,
        AUIPC     = 7'b0010111,
        LUI       = 7'b0110111
    } opcode_e;

    // Arithmetic func3
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // Branch func3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    // Which half of the product, and operand signedness
    typedef enum logic [1:0] {
        MUL_LO  = 2'd0,
        MUL_HSS = 2'd1,
        MUL_HSU = 2'd2,
        MUL_HUU = 2'd3
    } mul_kind_e;

endpackage

`default_nettype wire

// File: src/ex_op_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ex_op_if #(
    parameter int XLEN = ex_pkg::XLEN,
    parameter int PC_W = ex_pkg::PC_W
);
    // Latched instruction, stable from capture until the next request
    logic [6:0]      opcode;
    logic [2:0]      func3;
    logic [6:0]      func7;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] data1;
    logic [XLEN-1:0] data2;
    logic [PC_W-1:0] pc;

    modport src (output opcode, func3, func7, imm, data1, data2, pc);

    modport dst (input opcode, func3, func7, imm, data1, data2, pc);

endinterface

`default_nettype wire

// File: src/cla_adder.sv
`timescale 1ns/1ps
`default_nettype none

module cla_adder #(
    parameter int WIDTH = ex_pkg::XLEN
) (
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    input  logic             cin,
    output logic [WIDTH-1:0] sum,
    output logic             cout
);
    import ex_pkg::*;

    localparam int NGRP = WIDTH / LA_GROUP;

    logic [WIDTH-1:0] p;
    logic [WIDTH-1:0] g;
    logic [NGRP:0]    gc;

    assign p     = a ^ b;
    assign g     = a & b;
    assign gc[0] = cin;

    genvar gi, bi;
    generate
        if (WIDTH % LA_GROUP != 0) begin : bad_width
            $error("cla_adder WIDTH must be a multiple of LA_GROUP");
        end
        for (gi = 0; gi < NGRP; gi++) begin : grp
            localparam int LSB = gi * LA_GROUP;
            logic [LA_GROUP-1:0] c_loc;
            // Group generate, formed with zero carry-in
            logic [LA_GROUP:0]   g_chain;
            assign c_loc[0]   = gc[gi];
            assign g_chain[0] = 1'b0;
            for (bi = 0; bi < LA_GROUP; bi++) begin : bl
                if (bi > 0) begin : carry
                    assign c_loc[bi] = g[LSB+bi-1] | (p[LSB+bi-1] & c_loc[bi-1]);
                end
                assign g_chain[bi+1] = g[LSB+bi] | (p[LSB+bi] & g_chain[bi]);
                assign sum[LSB+bi]   = p[LSB+bi] ^ c_loc[bi];
            end
            // Carry to the next group skips the in-group ripple
            assign gc[gi+1] = g_chain[LA_GROUP] | ((&p[LSB +: LA_GROUP]) & gc[gi]);
        end
    endgenerate

    assign cout = gc[NGRP];

endmodule

`default_nettype wire

// File: src/int_alu.sv
`timescale 1ns/1ps
`default_nettype none

module int_alu #(
    parameter int XLEN = ex_pkg::XLEN
) (
    ex_op_if.dst            op,
    output logic [XLEN-1:0] alu_result
);
    import ex_pkg::*;

    opcode_e         opc;
    logic            is_op;
    logic            is_word;
    logic            legal;
    logic            sub_en;
    logic            arith;
    logic [XLEN-1:0] opb;
    logic [XLEN-1:0] upper_imm;
    logic [XLEN-1:0] add_a;
    logic [XLEN-1:0] add_b;
    logic [XLEN-1:0] sum;
    logic [5:0]      shamt;
    logic            lt_s;
    logic            lt_u;
    logic [XLEN-1:0] sra64;
    logic [31:0]     sll32;
    logic [31:0]     srl32;
    logic [31:0]     sra32;
    logic [31:0]     w_res;

    assign opc     = opcode_e'(op.opcode);
    assign is_op   = (opc == OP_64) || (opc == OP_32);
    assign is_word = (opc == OP_32) || (opc == OP_IMM_32);
    assign arith   = op.func7[5];
    assign sub_en  = is_op && (op.func3 == F3_ADD) && (op.func7 == F7_ALT);

    // Register forms take data2, everything else the immediate
    assign opb       = is_op ? op.data2 : op.imm;
    assign upper_imm = {{(XLEN-32){op.imm[19]}}, op.imm[19:0], 12'b0};

    always_comb begin
        if (is_op) begin
            legal = (op.func7 == F7_BASE) ||
                    ((op.func7 == F7_ALT) && ((op.func3 == F3_ADD) || (op.func3 == F3_SRL)));
        end else begin
            legal = 1'b1;
        end
        // Word forms only have add, sub and shifts
        if (is_word && !((op.func3 == F3_ADD) || (op.func3 == F3_SLL) || (op.func3 == F3_SRL))) begin
            legal = 1'b0;
        end
    end

    // Shared adder for add, sub, addresses and AUIPC
    assign add_a = (opc == AUIPC) ? XLEN'(op.pc) : op.data1;
    assign add_b = (opc == AUIPC) ? upper_imm : (sub_en ? ~opb : opb);

    cla_adder #(
        .WIDTH (XLEN)
    ) add_inst (
        .a    (add_a),
        .b    (add_b),
        .cin  (sub_en),
        .sum  (sum),
        .cout ()
    );

    assign shamt = opb[5:0];
    assign lt_s  = $signed(op.data1) < $signed(opb);
    assign lt_u  = op.data1 < opb;
    assign sra64 = $signed(op.data1) >>> shamt;

    // Word shifts see only 5 bits of amount
    assign sll32 = op.data1[31:0] << shamt[4:0];
    assign srl32 = op.data1[31:0] >> shamt[4:0];
    assign sra32 = $signed(op.data1[31:0]) >>> shamt[4:0];

    always_comb begin
        w_res      = sum[31:0];
        alu_result = '0;
        case (opc)
            OP_64, OP_IMM: begin
                if (legal) begin
                    case (op.func3)
                        F3_ADD:  alu_result = sum;
                        F3_SLL:  alu_result = op.data1 << shamt;
                        F3_SLT:  alu_result = {{(XLEN-1){1'b0}}, lt_s};
                        F3_SLTU: alu_result = {{(XLEN-1){1'b0}}, lt_u};
                        F3_XOR:  alu_result = op.data1 ^ opb;
                        F3_SRL:  alu_result = arith ? sra64 : (op.data1 >> shamt);
                        F3_OR:   alu_result = op.data1 | opb;
                        F3_AND:  alu_result = op.data1 & opb;
                        default: alu_result = '0;
                    endcase
                end
            end
            OP_32, OP_IMM_32: begin
                if (legal) begin
                    case (op.func3)
                        F3_SLL:  w_res = sll32;
                        F3_SRL:  w_res = arith ? sra32 : srl32;
                        default: w_res = sum[31:0];
                    endcase
                    alu_result = {{(XLEN-32){w_res[31]}}, w_res};
                end
            end
            LOAD, STORE, AUIPC: alu_result = sum;
            LUI:                alu_result = upper_imm;
            default:            alu_result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: src/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit #(
    parameter int XLEN = ex_pkg::XLEN,
    parameter int PC_W = ex_pkg::PC_W
) (
    ex_op_if.dst            op,
    output logic            taken,
    output logic [PC_W-1:0] target,
    output logic [XLEN-1:0] link
);
    import ex_pkg::*;

    opcode_e         opc;
    logic [PC_W-1:0] tgt_base;
    logic [PC_W-1:0] tgt_sum;
    logic [PC_W-1:0] fall_sum;
    logic            eq;
    logic            lt_s;
    logic            lt_u;
    logic            cond;

    assign opc = opcode_e'(op.opcode);

    // JALR is register relative, the rest PC relative
    assign tgt_base = (opc == JALR) ? op.data1[PC_W-1:0] : op.pc;

    cla_adder #(
        .WIDTH (PC_W)
    ) tgt_add_inst (
        .a    (tgt_base),
        .b    (op.imm[PC_W-1:0]),
        .cin  (1'b0),
        .sum  (tgt_sum),
        .cout ()
    );

    cla_adder #(
        .WIDTH (PC_W)
    ) seq_add_inst (
        .a    (op.pc),
        .b    (PC_W'(4)),
        .cin  (1'b0),
        .sum  (fall_sum),
        .cout ()
    );

    assign eq   = op.data1 == op.data2;
    assign lt_s = $signed(op.data1) < $signed(op.data2);
    assign lt_u = op.data1 < op.data2;

    always_comb begin
        case (op.func3)
            F3_BEQ:  cond = eq;
            F3_BNE:  cond = !eq;
            F3_BLT:  cond = lt_s;
            F3_BGE:  cond = !lt_s;
            F3_BLTU: cond = lt_u;
            F3_BGEU: cond = !lt_u;
            default: cond = 1'b0;
        endcase
    end

    always_comb begin
        taken  = 1'b0;
        target = '0;
        link   = '0;
        case (opc)
            BRANCH: begin
                taken  = cond;
                target = cond ? tgt_sum : fall_sum;
            end
            JAL, JALR: begin
                taken  = 1'b1;
                target = tgt_sum;
                link   = XLEN'(fall_sum);
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: src/shift_add_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module shift_add_multiplier #(
    parameter int XLEN = ex_pkg::XLEN
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic [XLEN-1:0]   a,
    input  logic [XLEN-1:0]   b,
    input  logic              a_signed,
    input  logic              b_signed,
    output logic              done,
    output logic [2*XLEN-1:0] product
);
    localparam int CNT_W = $clog2(XLEN);

    logic              a_neg;
    logic              b_neg;
    logic [XLEN-1:0]   a_mag;
    logic [XLEN-1:0]   b_mag;
    logic [XLEN-1:0]   mcand;
    // High half accumulates, low half shifts the multiplier out
    logic [2*XLEN-1:0] acc;
    logic [XLEN:0]     partial;
    logic              neg_q;
    logic              busy;
    logic [CNT_W-1:0]  cnt;

    assign a_neg = a_signed && a[XLEN-1];
    assign b_neg = b_signed && b[XLEN-1];
    assign a_mag = a_neg ? (~a + 1'b1) : a;
    assign b_mag = b_neg ? (~b + 1'b1) : b;

    assign partial = {1'b0, acc[2*XLEN-1:XLEN]} + (acc[0] ? {1'b0, mcand} : '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == CNT_W'(XLEN - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mcand <= a_mag;
            acc   <= {{XLEN{1'b0}}, b_mag};
            neg_q <= a_neg ^ b_neg;
        end else if (busy) begin
            acc <= {partial, acc[XLEN-1:1]};
        end
    end

    // Sign fixup, held until the next start
    assign product = neg_q ? (~acc + 1'b1) : acc;

endmodule

`default_nettype wire

// File: src/ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage #(
    parameter int XLEN = ex_pkg::XLEN,
    parameter int PC_W = ex_pkg::PC_W
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            req,
    input  logic [6:0]      opcode,
    input  logic [2:0]      func3,
    input  logic [6:0]      func7,
    input  logic [XLEN-1:0] imm,
    input  logic [XLEN-1:0] data1,
    input  logic [XLEN-1:0] data2,
    input  logic [PC_W-1:0] pc,
    output logic            ack,
    output logic [XLEN-1:0] result,
    output logic [PC_W-1:0] pc_branch,
    output logic            is_branch,
    output logic            mem_rw,
    output logic            is_load
);
    import ex_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_EXEC,
        S_MUL,
        S_ACK
    } state_e;

    state_e            state;
    logic              capture;
    logic [XLEN-1:0]   alu_result;
    logic              br_taken;
    logic [PC_W-1:0]   br_target;
    logic [XLEN-1:0]   br_link;
    logic              is_mul;
    mul_kind_e         mul_kind;
    logic              mul_start;
    logic              mul_done;
    logic [2*XLEN-1:0] mul_product;
    logic [XLEN-1:0]   mul_result;

    ex_op_if #(.XLEN(XLEN), .PC_W(PC_W)) op_bus ();

    assign capture = (state == S_IDLE) && req && !ack;

    always_ff @(posedge clk) begin
        if (capture) begin
            op_bus.opcode <= opcode;
            op_bus.func3  <= func3;
            op_bus.func7  <= func7;
            op_bus.imm    <= imm;
            op_bus.data1  <= data1;
            op_bus.data2  <= data2;
            op_bus.pc     <= pc;
        end
    end

    int_alu #(.XLEN(XLEN)) alu_inst (
        .op         (op_bus),
        .alu_result (alu_result)
    );

    branch_unit #(.XLEN(XLEN), .PC_W(PC_W)) br_inst (
        .op     (op_bus),
        .taken  (br_taken),
        .target (br_target),
        .link   (br_link)
    );

    // MUL, MULH, MULHSU, MULHU and MULW
    assign is_mul = (op_bus.func7 == F7_MULDIV) &&
                    (((op_bus.opcode == OP_64) && !op_bus.func3[2]) ||
                     ((op_bus.opcode == OP_32) && (op_bus.func3 == F3_ADD)));

    always_comb begin
        case (op_bus.func3)
            F3_SLL:  mul_kind = MUL_HSS;
            F3_SLT:  mul_kind = MUL_HSU;
            F3_SLTU: mul_kind = MUL_HUU;
            default: mul_kind = MUL_LO;
        endcase
    end

    assign mul_start = (state == S_EXEC) && is_mul;

    shift_add_multiplier #(.XLEN(XLEN)) mul_inst (
        .clk      (clk),
        .rst      (rst),
        .start    (mul_start),
        .a        (op_bus.data1),
        .b        (op_bus.data2),
        .a_signed ((mul_kind == MUL_HSS) || (mul_kind == MUL_HSU)),
        .b_signed (mul_kind == MUL_HSS),
        .done     (mul_done),
        .product  (mul_product)
    );

    // Low word of the product is the same for any signedness
    always_comb begin
        if (mul_kind != MUL_LO) begin
            mul_result = mul_product[2*XLEN-1:XLEN];
        end else if (op_bus.opcode == OP_32) begin
            mul_result = {{(XLEN-32){mul_product[31]}}, mul_product[31:0]};
        end else begin
            mul_result = mul_product[XLEN-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_IDLE;
            ack       <= 1'b0;
            result    <= '0;
            pc_branch <= '0;
            is_branch <= 1'b0;
            mem_rw    <= 1'b0;
            is_load   <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (capture) begin
                        state <= S_EXEC;
                    end
                end
                S_EXEC: begin
                    result    <= ((op_bus.opcode == JAL) || (op_bus.opcode == JALR)) ?
                                 br_link : alu_result;
                    pc_branch <= br_target;
                    is_branch <= br_taken;
                    is_load   <= op_bus.opcode == LOAD;
                    mem_rw    <= op_bus.opcode == STORE;
                    state     <= is_mul ? S_MUL : S_ACK;
                end
                S_MUL: begin
                    if (mul_done) begin
                        result <= mul_result;
                        ack    <= 1'b1;
                        state  <= S_ACK;
                    end
                end
                default: begin
                    // Ack held until the requester drops req
                    if (!ack) begin
                        ack <= 1'b1;
                    end else if (!req) begin
                        ack   <= 1'b0;
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: dv/ex_stage_sva.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage_sva #(
    parameter int XLEN = ex_pkg::XLEN,
    parameter int PC_W = ex_pkg::PC_W
) (
    input logic            clk,
    input logic            rst,
    input logic            req,
    input logic            ack,
    input logic [XLEN-1:0] result,
    input logic [PC_W-1:0] pc_branch,
    input logic            is_branch,
    input logic            mem_rw,
    input logic            is_load
);

    // One cycle into reset ack must be low
    ack_low_in_reset: assert property (@(posedge clk) rst |=> !ack)
        else $error("ack high during reset");

    // Ack may only drop after the requester releases req
    ack_held_with_req: assert property (
        @(posedge clk) disable iff (rst) (ack && req) |=> ack
    ) else $error("ack dropped while req still high");

    outputs_frozen: assert property (
        @(posedge clk) disable iff (rst)
        ack |=> (!ack || ($stable(result) && $stable(pc_branch) && $stable(is_branch) &&
                          $stable(mem_rw) && $stable(is_load)))
    ) else $error("outputs changed while ack high");

endmodule

bind ex_stage ex_stage_sva #(
    .XLEN (XLEN),
    .PC_W (PC_W)
) ex_stage_sva_inst (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .ack       (ack),
    .result    (result),
    .pc_branch (pc_branch),
    .is_branch (is_branch),
    .mem_rw    (mem_rw),
    .is_load   (is_load)
);

`default_nettype wire

// File: dv/tb_ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage;
    import ex_pkg::*;

    localparam logic [63:0] SGN  = 64'h8000_0000_0000_0000;
    localparam logic [63:0] ONES = 64'hffff_ffff_ffff_ffff;
    localparam logic [31:0] PC0  = 32'h0000_1000;
    localparam int N_RAND_MUL = 15;
    localparam int N_RAND_BR  = 12;

    typedef struct {
        logic [6:0]      opcode;
        logic [2:0]      func3;
        logic [6:0]      func7;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] data1;
        logic [XLEN-1:0] data2;
        logic [PC_W-1:0] pc;
        logic [XLEN-1:0] result;
        logic [PC_W-1:0] pc_branch;
        logic            is_branch;
        logic            is_load;
        logic            mem_rw;
        int              hold;
    } vec_t;

    logic            clk;
    logic            rst;
    logic            req;
    logic [6:0]      opcode;
    logic [2:0]      func3;
    logic [6:0]      func7;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] data1;
    logic [XLEN-1:0] data2;
    logic [PC_W-1:0] pc;
    logic            ack;
    logic [XLEN-1:0] result;
    logic [PC_W-1:0] pc_branch;
    logic            is_branch;
    logic            mem_rw;
    logic            is_load;

    vec_t        tbl[$];
    logic [31:0] lcg_state;
    int          cycles = 0;
    int          cycle_limit = 0;

    ex_stage #(.XLEN(XLEN), .PC_W(PC_W)) ex_stage_inst (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .opcode    (opcode),
        .func3     (func3),
        .func7     (func7),
        .imm       (imm),
        .data1     (data1),
        .data2     (data2),
        .pc        (pc),
        .ack       (ack),
        .result    (result),
        .pc_branch (pc_branch),
        .is_branch (is_branch),
        .mem_rw    (mem_rw),
        .is_load   (is_load)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: DUT did not finish within %0d cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $fatal(1, "run stopped by cycle limit");
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [63:0] rand64();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = lcg_next();
        lo = lcg_next();
        return {hi, lo};
    endfunction

    // Full 128-bit product of sign- or zero-extended operands
    function automatic logic [63:0] mul_model(input logic [6:0] op, input logic [2:0] f3,
                                              input logic [63:0] a, input logic [63:0] b);
        logic [127:0] ax;
        logic [127:0] bx;
        logic [127:0] p;
        ax = (f3 == 3'd1 || f3 == 3'd2) ? {{64{a[63]}}, a} : {64'd0, a};
        bx = (f3 == 3'd1) ? {{64{b[63]}}, b} : {64'd0, b};
        p  = ax * bx;
        if (op == OP_32) begin
            return {{32{p[31]}}, p[31:0]};
        end
        return (f3 == 3'd0) ? p[63:0] : p[127:64];
    endfunction

    function automatic logic branch_model(input logic [2:0] f3, input logic [63:0] a,
                                          input logic [63:0] b);
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return $signed(a) < $signed(b);
            F3_BGE:  return $signed(a) >= $signed(b);
            F3_BLTU: return a < b;
            F3_BGEU: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic add_vec(
        input logic [6:0]  op,
        input logic [2:0]  f3,
        input logic [6:0]  f7,
        input logic [63:0] imm_v,
        input logic [63:0] d1,
        input logic [63:0] d2,
        input logic [31:0] pc_v,
        input logic [63:0] res,
        input logic        br,
        input logic [31:0] pcb,
        input logic        ld,
        input logic        st
    );
        vec_t v;
        v = '{op, f3, f7, imm_v, d1, d2, pc_v, res, pcb, br, ld, st, 0};
        tbl.push_back(v);
    endtask

    task automatic add_alu(
        input logic [6:0]  op,
        input logic [2:0]  f3,
        input logic [6:0]  f7,
        input logic [63:0] imm_v,
        input logic [63:0] d1,
        input logic [63:0] d2,
        input logic [63:0] res
    );
        add_vec(op, f3, f7, imm_v, d1, d2, PC0, res, 1'b0, 32'd0, 1'b0, 1'b0);
    endtask

    task automatic add_branch(
        input logic [6:0]  op,
        input logic [2:0]  f3,
        input logic [63:0] imm_v,
        input logic [63:0] d1,
        input logic [63:0] d2,
        input logic [31:0] pc_v,
        input logic        br,
        input logic [31:0] pcb,
        input logic [63:0] res
    );
        add_vec(op, f3, F7_BASE, imm_v, d1, d2, pc_v, res, br, pcb, 1'b0, 1'b0);
    endtask

    task automatic build_table();
        int          i;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] imm_v;
        logic [31:0] r;
        logic [31:0] pc_v;
        logic [31:0] pcb;
        logic [2:0]  f3;
        logic [6:0]  op;
        logic        taken;
        // 64-bit register forms
        add_alu(OP_64, F3_ADD, F7_BASE, 0, SGN, ONES, 64'h7fff_ffff_ffff_ffff);
        tbl[tbl.size()-1].hold = 3;
        add_alu(OP_64, F3_ADD, F7_ALT, 0, 0, 1, ONES);
        add_alu(OP_64, F3_SLL, F7_BASE, 0, 1, 63, SGN);
        add_alu(OP_64, F3_SLT, F7_BASE, 0, SGN, 0, 1);
        add_alu(OP_64, F3_SLTU, F7_BASE, 0, SGN, 0, 0);
        add_alu(OP_64, F3_XOR, F7_BASE, 0, ONES, 64'h0f0f_0f0f_0f0f_0f0f, 64'hf0f0_f0f0_f0f0_f0f0);
        add_alu(OP_64, F3_SRL, F7_BASE, 0, SGN, 63, 1);
        add_alu(OP_64, F3_SRL, F7_ALT, 0, SGN, 63, ONES);
        add_alu(OP_64, F3_OR, F7_BASE, 0, SGN, 1, 64'h8000_0000_0000_0001);
        add_alu(OP_64, F3_AND, F7_BASE, 0, ONES, 0, 0);
        add_alu(OP_IMM, F3_ADD, F7_BASE, ONES, 5, 0, 4);
        add_alu(OP_IMM, F3_SLL, F7_BASE, 63, 3, 0, SGN);
        add_alu(OP_IMM, F3_SRL, F7_ALT, 4, 64'hf000_0000_0000_0000, 0, 64'hff00_0000_0000_0000);
        add_alu(OP_IMM, F3_SRL, F7_BASE, 63, ONES, 0, 1);
        add_alu(OP_IMM, F3_SLT, F7_BASE, 0, ONES, 0, 1);
        add_alu(OP_IMM, F3_SLTU, F7_BASE, ONES, SGN, 0, 1);
        add_alu(OP_IMM, F3_XOR, F7_BASE, ONES, SGN, 0, 64'h7fff_ffff_ffff_ffff);
        add_alu(OP_IMM, F3_OR, F7_BASE, 1, SGN, 0, 64'h8000_0000_0000_0001);
        add_alu(OP_IMM, F3_AND, F7_BASE, 64'hffff_ffff_ffff_f800, ONES, 0, 64'hffff_ffff_ffff_f800);
        // Word forms mask shift amounts to 5 bits
        add_alu(OP_32, F3_ADD, F7_BASE, 0, 64'h7fff_ffff, 1, 64'hffff_ffff_8000_0000);
        add_alu(OP_32, F3_ADD, F7_ALT, 0, 0, 1, ONES);
        add_alu(OP_32, F3_SLL, F7_BASE, 0, 1, 63, 64'hffff_ffff_8000_0000);
        add_alu(OP_32, F3_SRL, F7_BASE, 0, 64'hffff_ffff_8000_0000, 36, 64'h0800_0000);
        add_alu(OP_32, F3_SRL, F7_ALT, 0, 64'hffff_ffff_8000_0000, 4, 64'hffff_ffff_f800_0000);
        add_alu(OP_IMM_32, F3_ADD, F7_BASE, 1, 64'hffff_ffff, 0, 0);
        add_alu(OP_IMM_32, F3_SLL, F7_BASE, 31, 1, 0, 64'hffff_ffff_8000_0000);
        add_alu(OP_IMM_32, F3_SRL, F7_BASE, 31, ONES, 0, 1);
        add_alu(OP_IMM_32, F3_SRL, F7_ALT, 31, 64'h8000_0000, 0, ONES);
        // DIVW, DIV, REMU, REMW all give zero
        add_alu(OP_32, 3'b100, F7_MULDIV, 0, 100, 7, 0);
        add_alu(OP_64, 3'b100, F7_MULDIV, 0, 100, 7, 0);
        add_alu(OP_64, 3'b111, F7_MULDIV, 0, 100, 7, 0);
        add_alu(OP_32, 3'b110, F7_MULDIV, 0, 100, 7, 0);
        add_vec(LOAD, 3'b011, F7_BASE, 64'hffff_ffff_ffff_fff8, 64'h1000, 0, PC0,
                64'hff8, 1'b0, 32'd0, 1'b1, 1'b0);
        add_vec(STORE, 3'b011, F7_BASE, 64'h10, 64'h2000, 0, PC0,
                64'h2010, 1'b0, 32'd0, 1'b0, 1'b1);
        add_alu(AUIPC, 0, F7_BASE, 64'h8_0000, 0, 0, 64'hffff_ffff_8000_1000);
        add_alu(LUI, 0, F7_BASE, 64'h1_2345, 0, 0, 64'h1234_5000);
        add_alu(7'b1111111, 0, F7_BASE, 5, 5, 5, 0);
        add_branch(BRANCH, F3_BEQ, 64'h40, 5, 5, PC0, 1'b1, 32'h1040, 0);
        add_branch(BRANCH, F3_BEQ, 64'h40, 5, 6, PC0, 1'b0, 32'h1004, 0);
        add_branch(BRANCH, F3_BNE, 64'h40, 5, 6, PC0, 1'b1, 32'h1040, 0);
        add_branch(BRANCH, F3_BNE, 64'h40, 5, 5, PC0, 1'b0, 32'h1004, 0);
        add_branch(BRANCH, F3_BLT, 64'h40, ONES, 1, PC0, 1'b1, 32'h1040, 0);
        add_branch(BRANCH, F3_BLT, 64'h40, 1, ONES, PC0, 1'b0, 32'h1004, 0);
        add_branch(BRANCH, F3_BGE, 64'h40, 1, ONES, PC0, 1'b1, 32'h1040, 0);
        add_branch(BRANCH, F3_BGE, 64'h40, ONES, 1, PC0, 1'b0, 32'h1004, 0);
        add_branch(BRANCH, F3_BLTU, 64'h40, 1, ONES, PC0, 1'b1, 32'h1040, 0);
        add_branch(BRANCH, F3_BLTU, 64'h40, ONES, 1, PC0, 1'b0, 32'h1004, 0);
        add_branch(BRANCH, F3_BGEU, 64'h40, ONES, 1, PC0, 1'b1, 32'h1040, 0);
        add_branch(BRANCH, F3_BGEU, 64'h40, 1, ONES, PC0, 1'b0, 32'h1004, 0);
        add_branch(BRANCH, F3_BNE, 64'hffff_ffff_ffff_fff0, 1, 2, PC0, 1'b1, 32'h0ff0, 0);
        add_branch(JAL, 0, 64'h100, 0, 0, PC0, 1'b1, 32'h1100, 64'h1004);
        add_branch(JALR, 0, 64'h10, 64'h2003, 0, PC0, 1'b1, 32'h2013, 64'h1004);
        add_alu(OP_64, 3'b000, F7_MULDIV, 0, 64'hffff_ffff_ffff_fffd, 5, 64'hffff_ffff_ffff_fff1);
        add_alu(OP_64, 3'b001, F7_MULDIV, 0, ONES, ONES, 0);
        add_alu(OP_64, 3'b010, F7_MULDIV, 0, ONES, ONES, ONES);
        add_alu(OP_64, 3'b011, F7_MULDIV, 0, ONES, ONES, 64'hffff_ffff_ffff_fffe);
        add_alu(OP_32, 3'b000, F7_MULDIV, 0, 64'h7fff_ffff, 2, 64'hffff_ffff_ffff_fffe);
        tbl[tbl.size()-1].hold = 2;
        // Random multiplies of every kind with many negative operands
        for (i = 0; i < N_RAND_MUL; i++) begin
            a = rand64();
            b = rand64();
            if (i % 2 == 1) begin
                a[63] = 1'b1;
            end
            if (i % 3 == 0) begin
                b[63] = 1'b1;
            end
            f3 = (i % 5 == 4) ? 3'd0 : 3'(i % 5);
            op = (i % 5 == 4) ? OP_32 : OP_64;
            add_alu(op, f3, F7_MULDIV, 0, a, b, mul_model(op, f3, a, b));
        end
        for (i = 0; i < N_RAND_BR; i++) begin
            case (i % 6)
                0:       f3 = F3_BEQ;
                1:       f3 = F3_BNE;
                2:       f3 = F3_BLT;
                3:       f3 = F3_BGE;
                4:       f3 = F3_BLTU;
                default: f3 = F3_BGEU;
            endcase
            a = rand64();
            b = (i % 4 == 0) ? a : rand64();
            r = lcg_next();
            imm_v = {{52{r[11]}}, r[11:1], 1'b0};
            pc_v  = lcg_next() & 32'hffff_fffc;
            taken = branch_model(f3, a, b);
            pcb   = taken ? (pc_v + imm_v[31:0]) : (pc_v + 32'd4);
            add_branch(BRANCH, f3, imm_v, a, b, pc_v, taken, pcb, 0);
        end
    endtask

    task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic compare_outputs(input int idx, input vec_t v);
        check($sformatf("vec %0d ack", idx), ack, 1);
        check($sformatf("vec %0d result", idx), result, v.result);
        check($sformatf("vec %0d pc_branch", idx), pc_branch, v.pc_branch);
        check($sformatf("vec %0d is_branch", idx), is_branch, v.is_branch);
        check($sformatf("vec %0d is_load", idx), is_load, v.is_load);
        check($sformatf("vec %0d mem_rw", idx), mem_rw, v.mem_rw);
    endtask

    // One four-phase transaction entered on a falling edge with ack low
    task automatic run_vec(input int idx, input vec_t v);
        int   edges;
        int   i;
        logic mul;
        mul = (v.func7 == F7_MULDIV) &&
              (((v.opcode == OP_64) && !v.func3[2]) ||
               ((v.opcode == OP_32) && (v.func3 == F3_ADD)));
        opcode = v.opcode;
        func3  = v.func3;
        func7  = v.func7;
        imm    = v.imm;
        data1  = v.data1;
        data2  = v.data2;
        pc     = v.pc;
        req    = 1'b1;
        // Capture edge
        @(posedge clk);
        edges = 0;
        @(negedge clk);
        while (ack !== 1'b1) begin
            @(negedge clk);
            edges++;
        end
        if (mul) begin
            check($sformatf("vec %0d mul latency at least XLEN", idx), edges >= XLEN, 1);
        end else begin
            check($sformatf("vec %0d ack latency", idx), edges, 2);
        end
        compare_outputs(idx, v);
        for (i = 0; i < v.hold; i++) begin
            @(negedge clk);
            compare_outputs(idx, v);
        end
        req = 1'b0;
        while (ack !== 1'b0) begin
            @(negedge clk);
        end
    endtask

    initial begin
        rst       = 1'b1;
        req       = 1'b0;
        opcode    = '0;
        func3     = '0;
        func7     = '0;
        imm       = '0;
        data1     = '0;
        data2     = '0;
        pc        = '0;
        lcg_state = 32'h11a1_e00b;
        build_table();
        cycle_limit = tbl.size() * (XLEN + 6) + 100;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check("ack after reset", ack, 0);
        check("result after reset", result, 0);
        check("pc_branch after reset", pc_branch, 0);
        check("flags after reset", {is_branch, is_load, mem_rw}, 0);
        foreach (tbl[k]) begin
            run_vec(k, tbl[k]);
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
src/ex_pkg.sv
src/ex_op_if.sv
src/cla_adder.sv
src/int_alu.sv
src/branch_unit.sv
src/shift_add_multiplier.sv
src/ex_stage.sv
dv/ex_stage_sva.sv
dv/tb_ex_stage.sv
